// ==== common/detect_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Classified beat from the finder output stage
// ready is the top level out_ready, so the tracker sees the same handshake
interface detect_if;

    logic valid;    // Output register holds a beat
    logic ready;    // Downstream takes the beat this cycle
    logic hit;      // Pixel matched the selected colour
    logic sof;      // First pixel of a frame
    logic eol;      // Last pixel of a line

    // Finder side
    modport source (
        output valid,
        output hit,
        output sof,
        output eol,
        input  ready
    );

    // Tracker only looks, it never stalls the stream
    modport monitor (
        input valid,
        input ready,
        input hit,
        input sof,
        input eol
    );

endinterface

`default_nettype wire

// ==== common/vision_pkg.sv ====
`default_nettype none

package vision_pkg;

    // Frame geometry, fixed for the whole design
    localparam int frame_w = 16;    // Pixels per line
    localparam int frame_h = 12;    // Lines per frame
    localparam int coord_w = 4;     // Wide enough for both axes

    localparam int num_colors = 5;  // One class flag per colour window

    // Colour index, also the bit position inside the flag vector
    typedef enum logic [2:0] {
        color_orange = 3'd0,
        color_pink   = 3'd1,
        color_purple = 3'd2,
        color_blue   = 3'd3,
        color_green  = 3'd4
    } color_e;

    // RGB444 camera word
    // Whole word for the masked passthrough, nibble view for the windows
    typedef union packed {
        logic [11:0] bits;
        struct packed {
            logic [3:0] r;      // Red sits in the top nibble
            logic [3:0] g;
            logic [3:0] b;
        } ch;
    } pixel444_u;

    // Orange window
    localparam logic [3:0] thresh_r_min_orange = 4'd8;
    localparam logic [3:0] thresh_r_max_orange = 4'd15;
    localparam logic [3:0] thresh_g_min_orange = 4'd2;
    localparam logic [3:0] thresh_g_max_orange = 4'd5;
    localparam logic [3:0] thresh_b_max_orange = 4'd5;

    // Bright pink, strong red and blue with little green
    localparam logic [3:0] thresh_r_min_pink = 4'd12;
    localparam logic [3:0] thresh_g_max_pink = 4'd3;
    localparam logic [3:0] thresh_b_min_pink = 4'd10;

    // Dark purple, mid red and blue
    localparam logic [3:0] thresh_r_min_purple = 4'd6;
    localparam logic [3:0] thresh_r_max_purple = 4'd10;
    localparam logic [3:0] thresh_g_max_purple = 4'd3;
    localparam logic [3:0] thresh_b_min_purple = 4'd6;
    localparam logic [3:0] thresh_b_max_purple = 4'd10;

    // Bright blue
    localparam logic [3:0] thresh_r_max_blue = 4'd3;
    localparam logic [3:0] thresh_g_max_blue = 4'd7;
    localparam logic [3:0] thresh_b_min_blue = 4'd10;

    // Bright green
    localparam logic [3:0] thresh_r_max_green = 4'd4;
    localparam logic [3:0] thresh_g_min_green = 4'd10;
    localparam logic [3:0] thresh_g_max_green = 4'd15;
    localparam logic [3:0] thresh_b_max_green = 4'd4;

endpackage

`default_nettype wire

// ==== rtl/vision_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vision_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  vision_pkg::color_e                target_sel,   // Change only between frames

    // Camera stream in
    input  logic                              in_valid,
    output logic                              in_ready,
    input  vision_pkg::pixel444_u             in_pixel,
    input  logic                              in_sof,
    input  logic                              in_eol,

    // Masked RGB888 stream out
    output logic                              out_valid,
    input  logic                              out_ready,
    output logic [7:0]                        out_red,
    output logic [7:0]                        out_green,
    output logic [7:0]                        out_blue,
    output logic [vision_pkg::num_colors-1:0] out_flags,
    output logic                              out_sof,
    output logic                              out_eol,

    // Per-frame bounding box
    output logic                              box_valid,
    output logic                              box_found,
    output logic [vision_pkg::coord_w-1:0]    box_x_min,
    output logic [vision_pkg::coord_w-1:0]    box_x_max,
    output logic [vision_pkg::coord_w-1:0]    box_y_min,
    output logic [vision_pkg::coord_w-1:0]    box_y_max
);

    detect_if det_if ();

    // Tracker follows the same handshake as the output stream
    assign det_if.ready = out_ready;
    assign out_valid    = det_if.valid;
    assign out_sof      = det_if.sof;
    assign out_eol      = det_if.eol;

    target_finder target_finder_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .target_sel (target_sel),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_pixel   (in_pixel),
        .in_sof     (in_sof),
        .in_eol     (in_eol),
        .out_red    (out_red),
        .out_green  (out_green),
        .out_blue   (out_blue),
        .out_flags  (out_flags),
        .det        (det_if.source)
    );

    target_tracker target_tracker_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .det        (det_if.monitor),
        .box_valid  (box_valid),
        .box_found  (box_found),
        .box_x_min  (box_x_min),
        .box_x_max  (box_x_max),
        .box_y_min  (box_y_min),
        .box_y_max  (box_y_max)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and judge the run from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_vision_top -o tb_vision_top \
    && ./obj_dir/tb_vision_top > sim.log 2>&1 \
    || echo "test failed" >> sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0

// ==== target_finder/target_finder.sv ====
`timescale 1ns/1ps
`default_nettype none

module target_finder (
    input  logic                              clk,
    input  logic                              rst_n,
    input  vision_pkg::color_e                target_sel,   // Colour kept in the image
    input  logic                              in_valid,
    output logic                              in_ready,
    input  vision_pkg::pixel444_u             in_pixel,
    input  logic                              in_sof,
    input  logic                              in_eol,
    output logic [7:0]                        out_red,
    output logic [7:0]                        out_green,
    output logic [7:0]                        out_blue,
    output logic [vision_pkg::num_colors-1:0] out_flags,
    detect_if.source                          det
);

    import vision_pkg::*;

    logic [3:0]            r;           // Input channel views
    logic [3:0]            g;
    logic [3:0]            b;
    logic [num_colors-1:0] flags;       // Window results for the input pixel
    logic                  sel_hit;     // Selected colour matched
    logic                  load;        // Input beat accepted
    pixel444_u             pix_q;       // Kept pixel, or black

    assign r = in_pixel.ch.r;
    assign g = in_pixel.ch.g;
    assign b = in_pixel.ch.b;

    // Five fixed windows, all evaluated in parallel
    always_comb begin
        flags = '0;
        flags[color_orange] = (r >= thresh_r_min_orange) && (r <= thresh_r_max_orange) &&
                              (g >= thresh_g_min_orange) && (g <= thresh_g_max_orange) &&
                              (b <= thresh_b_max_orange);
        flags[color_pink]   = (r >= thresh_r_min_pink) &&
                              (g <= thresh_g_max_pink) &&
                              (b >= thresh_b_min_pink);
        flags[color_purple] = (r >= thresh_r_min_purple) && (r <= thresh_r_max_purple) &&
                              (g <= thresh_g_max_purple) &&
                              (b >= thresh_b_min_purple) && (b <= thresh_b_max_purple);
        flags[color_blue]   = (r <= thresh_r_max_blue) &&
                              (g <= thresh_g_max_blue) &&
                              (b >= thresh_b_min_blue);
        flags[color_green]  = (r <= thresh_r_max_green) &&
                              (g >= thresh_g_min_green) && (g <= thresh_g_max_green) &&
                              (b <= thresh_b_max_green);
    end

    assign sel_hit = flags[target_sel];

    // Empty stage, or one being drained this cycle, can take a new pixel
    assign in_ready = !det.valid || det.ready;
    assign load     = in_valid && in_ready;

    // Output stage occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            det.valid <= 1'b0;
        end else if (load) begin
            det.valid <= 1'b1;              // Refill, also covers drain-and-refill
        end else if (det.ready) begin
            det.valid <= 1'b0;
        end
    end

    // Payload only moves on an accepted input beat
    always_ff @(posedge clk) begin
        if (load) begin
            pix_q.bits <= sel_hit ? in_pixel.bits : 12'h000;   // Black when not selected
            out_flags  <= flags;
            det.hit    <= sel_hit;
            det.sof    <= in_sof;
            det.eol    <= in_eol;
        end
    end

    // Widen to RGB888 by repeating each nibble
    assign out_red   = {pix_q.ch.r, pix_q.ch.r};
    assign out_green = {pix_q.ch.g, pix_q.ch.g};
    assign out_blue  = {pix_q.ch.b, pix_q.ch.b};

    // A stalled beat stays put until the consumer takes it
    property p_hold_stalled;
        @(posedge clk) disable iff (!rst_n)
        det.valid && !det.ready |=>
            det.valid &&
            $stable({out_red, out_green, out_blue, out_flags}) &&
            $stable({det.hit, det.sof, det.eol});
    endproperty

    a_hold_stalled: assert property (p_hold_stalled)
        else $error("finder output changed while stalled");

endmodule

`default_nettype wire

// ==== target_finder/target_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module target_tracker (
    input  logic                           clk,
    input  logic                           rst_n,
    detect_if.monitor                      det,
    output logic                           box_valid,   // One cycle per frame
    output logic                           box_found,   // Any selected pixel seen
    output logic [vision_pkg::coord_w-1:0] box_x_min,
    output logic [vision_pkg::coord_w-1:0] box_x_max,
    output logic [vision_pkg::coord_w-1:0] box_y_min,
    output logic [vision_pkg::coord_w-1:0] box_y_max
);

    import vision_pkg::*;

    logic               beat;       // Accepted output beat
    logic               last;       // Final beat of the frame
    logic [coord_w-1:0] x;          // Position expected for the next beat
    logic [coord_w-1:0] y;
    logic [coord_w-1:0] cur_x;      // Position of the current beat
    logic [coord_w-1:0] cur_y;

    // Working box of the frame in flight
    logic               w_found;
    logic [coord_w-1:0] w_x_min;
    logic [coord_w-1:0] w_x_max;
    logic [coord_w-1:0] w_y_min;
    logic [coord_w-1:0] w_y_max;

    // Working box updated with the current beat
    logic               n_found;
    logic [coord_w-1:0] n_x_min;
    logic [coord_w-1:0] n_x_max;
    logic [coord_w-1:0] n_y_min;
    logic [coord_w-1:0] n_y_max;

    assign beat  = det.valid && det.ready;
    assign cur_x = det.sof ? '0 : x;    // sof always lands at the origin
    assign cur_y = det.sof ? '0 : y;
    assign last  = det.eol && (cur_y == coord_w'(frame_h - 1));

    always_comb begin
        // sof starts from an empty box
        n_found = det.sof ? 1'b0 : w_found;
        n_x_min = det.sof ? '0 : w_x_min;
        n_x_max = det.sof ? '0 : w_x_max;
        n_y_min = det.sof ? '0 : w_y_min;
        n_y_max = det.sof ? '0 : w_y_max;
        if (det.hit) begin
            if (!n_found) begin
                // First hit seeds all four edges
                n_x_min = cur_x;
                n_x_max = cur_x;
                n_y_min = cur_y;
                n_y_max = cur_y;
            end else begin
                if (cur_x < n_x_min) begin
                    n_x_min = cur_x;
                end
                if (cur_x > n_x_max) begin
                    n_x_max = cur_x;
                end
                if (cur_y < n_y_min) begin
                    n_y_min = cur_y;
                end
                if (cur_y > n_y_max) begin
                    n_y_max = cur_y;
                end
            end
            n_found = 1'b1;
        end
    end

    // Raster position
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x <= '0;
            y <= '0;
        end else if (beat) begin
            if (last) begin
                x <= '0;                    // Back to origin for the next frame
                y <= '0;
            end else if (det.eol) begin
                x <= '0;
                y <= cur_y + 1'b1;
            end else begin
                x <= cur_x + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_found   <= 1'b0;
            box_valid <= 1'b0;
            box_found <= 1'b0;
        end else begin
            box_valid <= beat && last;      // Pulse in the cycle after the last beat
            if (beat) begin
                w_found <= n_found;
            end
            if (beat && last) begin
                box_found <= n_found;
            end
        end
    end

    // Box edges are payload, qualified by the found bits
    always_ff @(posedge clk) begin
        if (beat) begin
            w_x_min <= n_x_min;
            w_x_max <= n_x_max;
            w_y_min <= n_y_min;
            w_y_max <= n_y_max;
        end
        if (beat && last) begin
            box_x_min <= n_x_min;           // Held until the next frame ends
            box_x_max <= n_x_max;
            box_y_min <= n_y_min;
            box_y_max <= n_y_max;
        end
    end

    // A new frame only opens once the previous one closed on its last line
    a_sof_at_origin: assert property (@(posedge clk) disable iff (!rst_n)
        beat && det.sof |-> (x == '0) && (y == '0))
        else $error("sof arrived in the middle of a frame");

    // Only the eol beat may sit in the last column
    a_x_in_line: assert property (@(posedge clk) disable iff (!rst_n)
        beat && !det.eol |-> cur_x < coord_w'(frame_w - 1))
        else $error("line longer than frame_w");

endmodule

`default_nettype wire

// ==== test/tb_vision_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vision_top;

    import vision_pkg::*;

    localparam int num_frames  = 8;
    localparam int cycle_limit = 2 * num_frames * frame_w * frame_h + 256;   // Plus drain margin

    logic                  clk;
    logic                  rst_n;
    color_e                target_sel;
    logic                  in_valid;
    logic                  in_ready;
    pixel444_u             in_pixel;
    logic                  in_sof;
    logic                  in_eol;
    logic                  out_valid;
    logic                  out_ready;
    logic [7:0]            out_red;
    logic [7:0]            out_green;
    logic [7:0]            out_blue;
    logic [num_colors-1:0] out_flags;
    logic                  out_sof;
    logic                  out_eol;
    logic                  box_valid;
    logic                  box_found;
    logic [coord_w-1:0]    box_x_min;
    logic [coord_w-1:0]    box_x_max;
    logic [coord_w-1:0]    box_y_min;
    logic [coord_w-1:0]    box_y_max;

    logic        ready_pat [cycle_limit];   // out_ready for each cycle
    logic [30:0] exp_q [$];                 // {flags, rgb888, sof, eol}
    logic [16:0] box_q [$];                 // {found, x_min, x_max, y_min, y_max}
    int          errors;
    int          cycles;
    int          in_count;
    int          out_count;
    int          box_count;

    vision_top vision_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .target_sel (target_sel),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_pixel   (in_pixel),
        .in_sof     (in_sof),
        .in_eol     (in_eol),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_red    (out_red),
        .out_green  (out_green),
        .out_blue   (out_blue),
        .out_flags  (out_flags),
        .out_sof    (out_sof),
        .out_eol    (out_eol),
        .box_valid  (box_valid),
        .box_found  (box_found),
        .box_x_min  (box_x_min),
        .box_x_max  (box_x_max),
        .box_y_min  (box_y_min),
        .box_y_max  (box_y_max)
    );

    always #4 clk = ~clk;    // 8 ns period

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Run timed out after %0d cycles with %0d of %0d output beats seen",
                     cycles, out_count, in_count);
            $display("errors: %0d", errors);
            $display("test failed");
            $finish;
        end
    end

    always @(negedge clk) out_ready = ready_pat[cycles];   // Random consumer stalls

    // Expected class flags, straight from the colour windows
    function automatic logic [4:0] classify(input logic [11:0] p);
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        logic [4:0] f;
        r = p[11:8];
        g = p[7:4];
        b = p[3:0];
        f[0] = (r >= 4'd8) && (g >= 4'd2) && (g <= 4'd5) && (b <= 4'd5);            // Orange
        f[1] = (r >= 4'd12) && (g <= 4'd3) && (b >= 4'd10);                         // Pink
        f[2] = (r >= 4'd6) && (r <= 4'd10) && (g <= 4'd3) && (b >= 4'd6) && (b <= 4'd10);
        f[3] = (r <= 4'd3) && (g <= 4'd7) && (b >= 4'd10);                          // Blue
        f[4] = (r <= 4'd4) && (g >= 4'd10) && (b <= 4'd4);                          // Green
        return f;
    endfunction

    function automatic logic [3:0] pick_in_range(input int lo, input int hi);
        return 4'(lo + int'($urandom % (hi - lo + 1)));    // Inclusive, so edges show up
    endfunction

    // Pixel inside the window of one colour
    function automatic logic [11:0] window_pixel(input int color);
        case (color)
            0:       return {pick_in_range(8, 15), pick_in_range(2, 5), pick_in_range(0, 5)};
            1:       return {pick_in_range(12, 15), pick_in_range(0, 3), pick_in_range(10, 15)};
            2:       return {pick_in_range(6, 10), pick_in_range(0, 3), pick_in_range(6, 10)};
            3:       return {pick_in_range(0, 3), pick_in_range(0, 7), pick_in_range(10, 15)};
            default: return {pick_in_range(0, 4), pick_in_range(10, 15), pick_in_range(0, 4)};
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Fail %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    // One input beat, starting on a falling edge, returns on the edge after the transfer
    task automatic send_pixel(input logic [11:0] pix, input logic sof, input logic eol);
        logic       fired;
        logic [4:0] flags;
        logic [23:0] rgb;
        fired = 1'b0;
        flags = classify(pix);
        rgb   = {pix[11:8], pix[11:8], pix[7:4], pix[7:4], pix[3:0], pix[3:0]};
        while (($urandom % 8) == 0) begin   // Idle gap on the input
            in_valid = 1'b0;
            @(negedge clk);
        end
        in_valid      = 1'b1;
        in_pixel.bits = pix;
        in_sof        = sof;
        in_eol        = eol;
        while (!fired) begin
            #2;
            fired = in_ready;               // Settled well before the rising edge
            @(negedge clk);
        end
        in_valid = 1'b0;
        in_count++;
        exp_q.push_back({flags, flags[target_sel] ? rgb : 24'h0, sof, eol});
    endtask

    // Stimulus and expected box per frame
    initial begin
        logic [11:0] pix;
        logic [4:0]  flags;
        logic        found;
        logic [3:0]  x_min;
        logic [3:0]  x_max;
        logic [3:0]  y_min;
        logic [3:0]  y_max;
        void'($urandom(32'h1df3));
        clk           = 1'b0;
        rst_n         = 1'b0;
        target_sel    = color_orange;
        in_valid      = 1'b0;
        in_pixel.bits = 12'h000;
        in_sof        = 1'b0;
        in_eol        = 1'b0;
        out_ready     = 1'b0;
        for (int i = 0; i < cycle_limit; i++) begin
            ready_pat[i] = ($urandom % 4) != 0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #2;
        check("out_valid after reset", 32'(0), 32'(out_valid));
        check("box_valid after reset", 32'(0), 32'(box_valid));
        check("box_found after reset", 32'(0), 32'(box_found));
        check("in_ready after reset", 32'(1), 32'(in_ready));
        @(negedge clk);
        for (int f = 0; f < num_frames; f++) begin
            while (exp_q.size() != 0 || box_q.size() != 0) begin
                @(negedge clk);             // No frame in flight when the colour changes
            end
            target_sel = color_e'(f % num_colors);
            found = 1'b0;
            x_min = '0;
            x_max = '0;
            y_min = '0;
            y_max = '0;
            for (int y = 0; y < frame_h; y++) begin
                for (int x = 0; x < frame_w; x++) begin
                    pix = 12'($urandom);
                    if ((f % 2) == 1 && ($urandom % 3) == 0) begin
                        pix = window_pixel(int'($urandom % num_colors));
                    end
                    flags = classify(pix);
                    if (f == 2 && flags[target_sel]) begin
                        pix   = 12'h000;    // Frame 2 holds no selected pixel at all
                        flags = classify(pix);
                    end
                    if (flags[target_sel]) begin
                        x_min = (!found || 4'(x) < x_min) ? 4'(x) : x_min;
                        x_max = (!found || 4'(x) > x_max) ? 4'(x) : x_max;
                        y_min = (!found || 4'(y) < y_min) ? 4'(y) : y_min;
                        y_max = (!found || 4'(y) > y_max) ? 4'(y) : y_max;
                        found = 1'b1;
                    end
                    send_pixel(pix, x == 0 && y == 0, x == frame_w - 1);
                end
            end
            box_q.push_back({found, x_min, x_max, y_min, y_max});
        end
        while (exp_q.size() != 0 || box_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);          // Catch any stray extra beat or pulse
        check("output beat count", 32'(in_count), 32'(out_count));
        check("box_valid count", 32'(num_frames), 32'(box_count));
        $display("errors: %0d, input beats: %0d, output beats: %0d, boxes: %0d",
                 errors, in_count, out_count, box_count);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Output side compare, sampled mid low phase
    initial begin
        logic [30:0] now_beat;
        logic [30:0] held_beat;
        logic [30:0] exp_beat;
        logic [16:0] exp_box;
        logic        held;
        held      = 1'b0;
        held_beat = '0;
        forever begin
            @(negedge clk);
            #2;
            now_beat = {out_flags, out_red, out_green, out_blue, out_sof, out_eol};
            if (held) begin                 // Stalled last cycle, nothing may move
                check("out_valid while stalled", 32'(1), 32'(out_valid));
                check("out beat while stalled", 32'(held_beat), 32'(now_beat));
            end
            held      = out_valid && !out_ready;
            held_beat = now_beat;
            if (out_valid && out_ready) begin
                out_count++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Output beat at %0t with no input beat waiting for it", $time);
                end else begin
                    exp_beat = exp_q.pop_front();
                    check("out_flags", 32'(exp_beat[30:26]), 32'(out_flags));
                    check("out_red", 32'(exp_beat[25:18]), 32'(out_red));
                    check("out_green", 32'(exp_beat[17:10]), 32'(out_green));
                    check("out_blue", 32'(exp_beat[9:2]), 32'(out_blue));
                    check("out_sof", 32'(exp_beat[1]), 32'(out_sof));
                    check("out_eol", 32'(exp_beat[0]), 32'(out_eol));
                end
            end
            if (box_valid) begin
                box_count++;
                if (box_q.size() == 0) begin
                    errors++;
                    $display("box_valid at %0t before any frame was complete", $time);
                end else begin
                    exp_box = box_q.pop_front();
                    check("box_found", 32'(exp_box[16]), 32'(box_found));
                    if (exp_box[16]) begin  // Edges only mean something with a hit
                        check("box_x_min", 32'(exp_box[15:12]), 32'(box_x_min));
                        check("box_x_max", 32'(exp_box[11:8]), 32'(box_x_max));
                        check("box_y_min", 32'(exp_box[7:4]), 32'(box_y_min));
                        check("box_y_max", 32'(exp_box[3:0]), 32'(box_y_max));
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/vision_pkg.sv
common/detect_if.sv
target_finder/target_finder.sv
target_finder/target_tracker.sv
rtl/vision_top.sv
test/tb_vision_top.sv
